// File: ksa_pkg.sv
// geometry of the fixed 8-bit Kogge-Stone adder
// KSA_STAGES must equal log2(KSA_WIDTH) for the prefix tree to close
// the width is not meant to be changed on its own
package ksa_pkg;

    // operand and sum width in bits
    localparam int KSA_WIDTH = 8;

    // prefix levels at distances 1, 2, 4
    localparam int KSA_STAGES = 3;

endpackage

// File: alu_pkg.sv
// op codes and flag count of the add/subtract unit
// op codes are OP_W bits wide and dense from 0 to 3
// subtract ops use the invert-and-add-one form, so carry out is "no borrow"
package alu_pkg;

    // op code width
    localparam int OP_W = 2;

    // plain add, carry-in 0
    localparam logic [OP_W-1:0] OP_ADD = 2'd0;
    // plain subtract, b inverted, carry-in 1
    localparam logic [OP_W-1:0] OP_SUB = 2'd1;
    // add with the stored carry flag
    localparam logic [OP_W-1:0] OP_ADC = 2'd2;
    // subtract with borrow, b inverted, stored carry as carry-in
    localparam logic [OP_W-1:0] OP_SBC = 2'd3;

    // carry, zero, overflow
    localparam int FLAG_W = 3;

endpackage

// File: operand_stage.sv
// input register of the add/subtract unit, one cycle of latency
// operands and op are captured only on a valid strobe
// carry-in for chained ops comes combinationally from the result side
`timescale 1ns/1ps

module operand_stage import ksa_pkg::*, alu_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_valid,
    input  logic [OP_W-1:0]      i_op,
    input  logic [KSA_WIDTH-1:0] i_data_a,
    input  logic [KSA_WIDTH-1:0] i_data_b,
    input  logic                 i_carry_flag,
    output logic                 o_valid,
    output logic [KSA_WIDTH-1:0] o_data_a,
    output logic [KSA_WIDTH-1:0] o_data_b,
    output logic                 o_carry_in
);

    logic                 valid_q;
    logic [OP_W-1:0]      op_q;
    logic [KSA_WIDTH-1:0] data_a_q;
    logic [KSA_WIDTH-1:0] data_b_q;
    logic                 is_sub;

    // strobe and op code
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            op_q    <= OP_ADD;
        end else begin
            valid_q <= i_valid;
            if (i_valid) begin
                op_q <= i_op;
            end
        end
    end

    // operand registers, loaded with the strobe
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            data_a_q <= i_data_a;
            data_b_q <= i_data_b;
        end
    end

    // both subtract flavours invert b
    assign is_sub = (op_q == OP_SUB) || (op_q == OP_SBC);

    // carry-in select
    // stored flag is the previous op's carry, already registered on this edge
    always_comb begin
        case (op_q)
            OP_ADD:  o_carry_in = 1'b0;
            OP_SUB:  o_carry_in = 1'b1;
            OP_ADC:  o_carry_in = i_carry_flag;
            OP_SBC:  o_carry_in = i_carry_flag;
            default: o_carry_in = 1'b0;
        endcase
    end

    assign o_valid  = valid_q;
    assign o_data_a = data_a_q;
    // effective b into the adder
    assign o_data_b = is_sub ? ~data_b_q : data_b_q;

endmodule

// File: ksa_8bit.sv
// combinational Kogge-Stone adder with carry-in and carry-out
// fixed at KSA_WIDTH bits with KSA_STAGES prefix levels
// white cells form g and p, black cells merge prefixes, gray cells form carries
`timescale 1ns/1ps

module ksa_8bit import ksa_pkg::*; (
    input  logic                 i_carry,
    input  logic [KSA_WIDTH-1:0] i_data_a,
    input  logic [KSA_WIDTH-1:0] i_data_b,
    output logic [KSA_WIDTH-1:0] o_sum,
    output logic                 o_carry
);

    // generate/propagate per prefix level
    // level 0 is bitwise, level KSA_STAGES spans bits 0..i
    logic [KSA_STAGES:0][KSA_WIDTH-1:0] g_lvl;
    logic [KSA_STAGES:0][KSA_WIDTH-1:0] p_lvl;

    // carry into each bit, top entry is carry out
    logic [KSA_WIDTH:0] carry;

    genvar lv;
    genvar bt;

    // white cells
    assign g_lvl[0] = i_data_a & i_data_b;
    assign p_lvl[0] = i_data_a ^ i_data_b;

    // black cells at distance 1, 2, 4
    generate
        for (lv = 0; lv < KSA_STAGES; lv++) begin : g_level
            for (bt = 0; bt < KSA_WIDTH; bt++) begin : g_bit
                if (bt >= (1 << lv)) begin : g_black
                    // merge with the group (1 << lv) bits below
                    assign g_lvl[lv+1][bt] = g_lvl[lv][bt]
                                           | (p_lvl[lv][bt] & g_lvl[lv][bt-(1<<lv)]);
                    assign p_lvl[lv+1][bt] = p_lvl[lv][bt]
                                           & p_lvl[lv][bt-(1<<lv)];
                end else begin : g_pass
                    // low bits already reach bit 0, carried through
                    assign g_lvl[lv+1][bt] = g_lvl[lv][bt];
                    assign p_lvl[lv+1][bt] = p_lvl[lv][bt];
                end
            end
        end
    endgenerate

    assign carry[0] = i_carry;

    // gray cells
    // group 0..i either generates or propagates the carry-in
    generate
        for (bt = 0; bt < KSA_WIDTH; bt++) begin : g_gray
            assign carry[bt+1] = g_lvl[KSA_STAGES][bt]
                               | (p_lvl[KSA_STAGES][bt] & i_carry);
        end
    endgenerate

    // sum is bitwise propagate xor incoming carry
    assign o_sum   = p_lvl[0] ^ carry[KSA_WIDTH-1:0];
    assign o_carry = carry[KSA_WIDTH];

endmodule

// File: result_stage.sv
// output register of the add/subtract unit, one cycle of latency
// flags change only on valid cycles and hold in between
// o_carry_flag feeds the chained ops, 0 after reset
`timescale 1ns/1ps

module result_stage import ksa_pkg::*, alu_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_valid,
    input  logic [KSA_WIDTH-1:0] i_sum,
    input  logic                 i_carry,
    input  logic                 i_a_msb,
    input  logic                 i_b_msb,
    output logic                 o_valid,
    output logic [KSA_WIDTH-1:0] o_result,
    output logic                 o_carry,
    output logic                 o_zero,
    output logic                 o_overflow,
    output logic                 o_carry_flag
);

    logic                 valid_q;
    logic [KSA_WIDTH-1:0] result_q;
    // {carry, zero, overflow}
    logic [FLAG_W-1:0]    flags_q;
    logic                 zero_d;
    logic                 overflow_d;

    // all-zero sum
    assign zero_d = ~|i_sum;

    // signs agree going in, sum sign differs
    assign overflow_d = (i_a_msb == i_b_msb) && (i_sum[KSA_WIDTH-1] != i_a_msb);

    // valid pulse and flags
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            flags_q <= '0;
        end else begin
            valid_q <= i_valid;
            if (i_valid) begin
                flags_q <= {i_carry, zero_d, overflow_d};
            end
        end
    end

    // result word
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            result_q <= i_sum;
        end
    end

    assign o_valid      = valid_q;
    assign o_result     = result_q;
    assign o_carry      = flags_q[2];
    assign o_zero       = flags_q[1];
    assign o_overflow   = flags_q[0];
    // same register, kept as the stored carry of the last result
    assign o_carry_flag = flags_q[2];

endmodule

// File: addsub_top.sv
// 8-bit add/subtract unit, two cycles from i_valid to o_valid
// one op per cycle, no back-pressure, results must be taken as they come
// adder is a KSA_STAGES level Kogge-Stone tree between the two registers
`timescale 1ns/1ps

module addsub_top import ksa_pkg::*, alu_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_valid,
    input  logic [OP_W-1:0]      i_op,
    input  logic [KSA_WIDTH-1:0] i_data_a,
    input  logic [KSA_WIDTH-1:0] i_data_b,
    output logic                 o_valid,
    output logic [KSA_WIDTH-1:0] o_result,
    output logic                 o_carry,
    output logic                 o_zero,
    output logic                 o_overflow
);

    logic                 op_valid;
    logic [KSA_WIDTH-1:0] op_a;
    logic [KSA_WIDTH-1:0] op_b;
    logic                 op_carry_in;
    logic [KSA_WIDTH-1:0] sum;
    logic                 sum_carry;
    // carry of the latest result, back to the operand side
    logic                 carry_flag;

    operand_stage operand_stage_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_op         (i_op),
        .i_data_a     (i_data_a),
        .i_data_b     (i_data_b),
        .i_carry_flag (carry_flag),
        .o_valid      (op_valid),
        .o_data_a     (op_a),
        .o_data_b     (op_b),
        .o_carry_in   (op_carry_in)
    );

    // purely combinational between the two registers
    ksa_8bit ksa_8bit_i (
        .i_carry  (op_carry_in),
        .i_data_a (op_a),
        .i_data_b (op_b),
        .o_sum    (sum),
        .o_carry  (sum_carry)
    );

    // sign bits of a and effective b for overflow
    result_stage result_stage_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (op_valid),
        .i_sum        (sum),
        .i_carry      (sum_carry),
        .i_a_msb      (op_a[KSA_WIDTH-1]),
        .i_b_msb      (op_b[KSA_WIDTH-1]),
        .o_valid      (o_valid),
        .o_result     (o_result),
        .o_carry      (o_carry),
        .o_zero       (o_zero),
        .o_overflow   (o_overflow),
        .o_carry_flag (carry_flag)
    );

endmodule

// File: tb_addsub.sv
// self-checking testbench for addsub_top
// random ops from a fixed xorshift seed, checked against an in-order model
// expects exactly two cycles from a driven strobe to o_valid, no back-pressure
`timescale 1ns/1ps

module tb_addsub
    import ksa_pkg::*, alu_pkg::*;
();

    // ops per phase
    localparam int N_RAND   = 200;
    localparam int N_CHAIN  = 200;
    localparam int N_CORNER = 64;
    localparam int N_BURST  = 200;
    // one extra for the first chained op after reset
    localparam int N_OPS    = 1 + N_RAND + N_CHAIN + N_CORNER + N_BURST;
    // worst case two cycles per op, plus reset, idle and drain
    localparam int TIMEOUT_CYCLES = N_OPS * 2 + 50;
    localparam int LATENCY  = 2;
    localparam logic [31:0] SEED = 32'h6868_681e;
    // signed range of one word
    localparam int S_MAX = (1 << (KSA_WIDTH - 1)) - 1;
    localparam int S_MIN = -(1 << (KSA_WIDTH - 1));

    logic                 i_clk = 1'b0;
    logic                 i_rst_n;
    logic                 i_valid;
    logic [OP_W-1:0]      i_op;
    logic [KSA_WIDTH-1:0] i_data_a;
    logic [KSA_WIDTH-1:0] i_data_b;
    logic                 o_valid;
    logic [KSA_WIDTH-1:0] o_result;
    logic                 o_carry;
    logic                 o_zero;
    logic                 o_overflow;

    logic [31:0]          rng_state = SEED;
    int                   cycle = 0;
    // model carry, kept in issue order
    logic                 model_carry = 1'b0;

    // scoreboard, expected values in issue order
    logic [KSA_WIDTH-1:0] exp_result[$];
    logic [FLAG_W-1:0]    exp_flags[$];
    int                   exp_due[$];

    addsub_top addsub_top_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_op       (i_op),
        .i_data_a   (i_data_a),
        .i_data_b   (i_data_b),
        .o_valid    (o_valid),
        .o_result   (o_result),
        .o_carry    (o_carry),
        .o_zero     (o_zero),
        .o_overflow (o_overflow)
    );

    always #10 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // corner operands 0x00, 0xFF, 0x7F, 0x80
    function automatic logic [KSA_WIDTH-1:0] corner(input int idx);
        case (idx)
            0:       return 8'h00;
            1:       return 8'hFF;
            2:       return 8'h7F;
            default: return 8'h80;
        endcase
    endfunction

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_result(input string name, input logic [KSA_WIDTH-1:0] exp_v,
                                input logic [KSA_WIDTH-1:0] act_v);
        if (act_v !== exp_v) begin
            stop_on_error($sformatf("MISMATCH at %0t: %s expected 8'h%02h got 8'h%02h",
                                    $time, name, exp_v, act_v));
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            stop_on_error($sformatf("MISMATCH at %0t: %s expected %b got %b",
                                    $time, name, exp_v, act_v));
        end
    endtask

    // reference arithmetic on plain integers
    // subtract carry means no borrow, overflow is the signed range check
    task automatic model_op(input logic [OP_W-1:0] op, input logic [KSA_WIDTH-1:0] a,
                            input logic [KSA_WIDTH-1:0] b, input logic cin,
                            output logic [KSA_WIDTH-1:0] res,
                            output logic [FLAG_W-1:0] flags);
        int ua;
        int ub;
        int sa;
        int sb;
        int ci;
        int ufull;
        int sfull;
        ua = int'(a);
        ub = int'(b);
        sa = a[KSA_WIDTH-1] ? ua - (1 << KSA_WIDTH) : ua;
        sb = b[KSA_WIDTH-1] ? ub - (1 << KSA_WIDTH) : ub;
        ci = cin ? 1 : 0;
        case (op)
            OP_ADD: begin
                ufull = ua + ub;
                sfull = sa + sb;
            end
            OP_SUB: begin
                ufull = ua - ub + (1 << KSA_WIDTH);
                sfull = sa - sb;
            end
            OP_ADC: begin
                ufull = ua + ub + ci;
                sfull = sa + sb + ci;
            end
            default: begin
                // borrow in is the inverted carry
                ufull = ua - ub - (1 - ci) + (1 << KSA_WIDTH);
                sfull = sa - sb - (1 - ci);
            end
        endcase
        res   = ufull[KSA_WIDTH-1:0];
        flags = {ufull[KSA_WIDTH], (res == '0), (sfull > S_MAX) || (sfull < S_MIN)};
    endtask

    task automatic drive_op(input logic [OP_W-1:0] op, input logic [KSA_WIDTH-1:0] a,
                            input logic [KSA_WIDTH-1:0] b);
        @(posedge i_clk);
        i_valid  <= 1'b1;
        i_op     <= op;
        i_data_a <= a;
        i_data_b <= b;
    endtask

    task automatic drive_random(input logic [OP_W-1:0] op);
        rng_state = xorshift32(rng_state);
        drive_op(op, rng_state[KSA_WIDTH-1:0], rng_state[2*KSA_WIDTH-1:KSA_WIDTH]);
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge i_clk);
            rng_state = xorshift32(rng_state);
            i_valid  <= 1'b0;
            // junk on the other lines, must be ignored without a strobe
            i_op     <= rng_state[OP_W-1:0];
            i_data_a <= rng_state[15:8];
            i_data_b <= rng_state[23:16];
        end
    endtask

    // cycle count and timeout
    always @(posedge i_clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout: run still going after %0d cycles", cycle));
        end
    end

    // sample on the falling edge, everything is settled there
    always @(negedge i_clk) begin
        logic [KSA_WIDTH-1:0] m_res;
        logic [FLAG_W-1:0]    m_flags;
        logic [FLAG_W-1:0]    e_flags;
        int                   due;
        if (o_valid) begin
            if (exp_due.size() == 0) begin
                stop_on_error("o_valid pulsed with no op outstanding");
            end else begin
                due = exp_due.pop_front();
                if (cycle != due) begin
                    stop_on_error($sformatf("result came in cycle %0d, expected cycle %0d",
                                            cycle, due));
                end
                check_result("o_result", exp_result.pop_front(), o_result);
                // {carry, zero, overflow}
                e_flags = exp_flags.pop_front();
                check_flag("o_carry", e_flags[2], o_carry);
                check_flag("o_zero", e_flags[1], o_zero);
                check_flag("o_overflow", e_flags[0], o_overflow);
            end
        end else if (exp_due.size() != 0 && exp_due[0] <= cycle) begin
            stop_on_error("an expected o_valid did not arrive");
        end
        // issue side, strobe seen here is taken on the next rising edge
        if (i_rst_n && i_valid) begin
            model_op(i_op, i_data_a, i_data_b, model_carry, m_res, m_flags);
            model_carry = m_flags[2];
            exp_result.push_back(m_res);
            exp_flags.push_back(m_flags);
            exp_due.push_back(cycle + LATENCY);
        end
    end

    initial begin
        logic gap;
        i_rst_n  <= 1'b0;
        i_valid  <= 1'b0;
        i_op     <= OP_ADD;
        i_data_a <= '0;
        i_data_b <= '0;
        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;
        // quiet after reset, a stray o_valid fails in the monitor
        drive_idle(5);
        // carry-in must be 0 here, else 0xFF turns into 0x00
        drive_op(OP_ADC, 8'hFF, 8'h00);
        // add and subtract with random gaps
        for (int i = 0; i < N_RAND; i++) begin
            rng_state = xorshift32(rng_state);
            gap = rng_state[24];
            drive_random(rng_state[25] ? OP_SUB : OP_ADD);
            if (gap) begin
                drive_idle(1);
            end
        end
        // back-to-back chained ops
        for (int i = 0; i < N_CHAIN; i++) begin
            rng_state = xorshift32(rng_state);
            drive_random(rng_state[3] ? OP_SBC : OP_ADC);
        end
        // every corner pair under every op, op codes are dense
        for (int ia = 0; ia < 4; ia++) begin
            for (int ib = 0; ib < 4; ib++) begin
                for (int k = 0; k < 4; k++) begin
                    drive_op(OP_W'(k), corner(ia), corner(ib));
                end
            end
        end
        // strobe every cycle, any op
        for (int i = 0; i < N_BURST; i++) begin
            rng_state = xorshift32(rng_state);
            drive_random(rng_state[OP_W-1:0]);
        end
        drive_idle(1);
        // fixed latency, every result is out a few cycles past it
        repeat (LATENCY + 4) @(negedge i_clk);
        if (exp_due.size() != 0) begin
            stop_on_error("results still outstanding at end of run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: all.f
ksa_pkg.sv
alu_pkg.sv
operand_stage.sv
ksa_8bit.sv
result_stage.sv
addsub_top.sv
tb_addsub.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
# exit status is non-zero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_addsub -f all.f -o tb_addsub
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/tb_addsub
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
